/* source/rvPkg.sv */
package rvPkg;

	localparam int xlen = 32;

	typedef enum logic [6:0] {
		opJal    = 7'b1101111,
		opItype  = 7'b0010011,
		opRtype  = 7'b0110011,
		opJalr   = 7'b1100111,
		opBranch = 7'b1100011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011
	} opcodeT;

	// stIdle only holds the core while in reset
	typedef enum logic [3:0] {
		stIdle     = 4'd0,
		stFetch    = 4'd1,
		stDecode   = 4'd2,
		stJal      = 4'd3,
		stMemWr    = 4'd4,
		stAddrCalc = 4'd5,
		stMemWb    = 4'd6,
		stRexec    = 4'd7,
		stJalr     = 4'd8,
		stBranch   = 4'd9,
		stBrDone   = 4'd10,
		stAluWb    = 4'd11,
		stMemRd    = 4'd12
	} stateT;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcodeT     opcode;
	} rFmtT;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcodeT      opcode;
	} iFmtT;

	typedef struct packed {
		logic [6:0] imm11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm4_0;
		opcodeT     opcode;
	} sFmtT;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		opcodeT     opcode;
	} bFmtT;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		opcodeT     opcode;
	} jFmtT;

	// One fetched word, seen through every format
	typedef union packed {
		rFmtT rFmt;
		iFmtT iFmt;
		sFmtT sFmt;
		bFmtT bFmt;
		jFmtT jFmt;
	} instrT;

	// Operand and source selects
	localparam logic       aPc      = 1'b0;
	localparam logic       aRs1     = 1'b1;
	localparam logic [1:0] bRs2     = 2'd0;
	localparam logic [1:0] bImm     = 2'd1;
	localparam logic [1:0] bFour    = 2'd2;
	localparam logic [1:0] pcAlu    = 2'd0;
	localparam logic [1:0] pcAluOut = 2'd1;
	localparam logic       wbAluOut = 1'b0;
	localparam logic       wbMdr    = 1'b1;

	typedef struct packed {
		logic       pcWr;
		logic       pcWrCond;
		logic       irWr;
		logic       rfWe;
		logic       aSel;
		logic [1:0] bSel;
		logic [1:0] pcSrc;
		logic       wbSel;
		stateT      state;
	} ctrlT;

	typedef struct packed {
		logic            csN;
		logic [xlen-1:0] addr;
	} iMemReqT;

	typedef struct packed {
		logic            csN;
		logic            wEn; // Active low
		logic [3:0]      be;
		logic [xlen-1:0] addr;
		logic [xlen-1:0] wData;
	} dMemReqT;

endpackage

/* source/regFile.sv */
`timescale 1ns/1ps

module regFile (
	input  logic                   CLK,
	input  logic [4:0]             rAddr1,
	input  logic [4:0]             rAddr2,
	input  logic [4:0]             wAddr,
	input  logic                   wEn,
	input  logic [rvPkg::xlen-1:0] wData,
	output logic [rvPkg::xlen-1:0] rData1,
	output logic [rvPkg::xlen-1:0] rData2
);
	import rvPkg::*;

	logic [xlen-1:0] regs [0:31];

	always_ff @(posedge CLK) begin
		if (wEn && wAddr != 5'd0) begin
			regs[wAddr] <= wData;
		end
	end

	// x0 never written and always reads zero
	assign rData1 = (rAddr1 == 5'd0) ? '0 : regs[rAddr1];
	assign rData2 = (rAddr2 == 5'd0) ? '0 : regs[rAddr2];

endmodule

/* source/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
	input  logic [rvPkg::xlen-1:0] a,
	input  logic [rvPkg::xlen-1:0] b,
	input  rvPkg::instrT           instr,
	input  rvPkg::stateT           state,
	output logic [rvPkg::xlen-1:0] result,
	output logic                   zero
);
	import rvPkg::*;

	logic isRexec;
	logic sltBit;

	assign isRexec = (state == stRexec) && (instr.rFmt.opcode == opRtype);
	assign sltBit  = $signed(a) < $signed(b);

	always_comb begin
		result = a + b; // Address, PC and immediate math
		if (state == stBranch) begin
			result = a - b; // Compare for the zero flag
		end else if (isRexec) begin
			case (instr.rFmt.funct3)
				3'b000: begin
					if (instr.rFmt.funct7[5]) begin
						result = a - b;
					end else begin
						result = a + b;
					end
				end
				3'b001: result = a << b[4:0];
				3'b010: result = {{(xlen-1){1'b0}}, sltBit};
				3'b100: result = a ^ b;
				3'b101: result = a >> b[4:0]; // Logical only
				3'b110: result = a | b;
				3'b111: result = a & b;
				default: result = a + b;
			endcase
		end
	end

	assign zero = (result == '0);

endmodule

/* source/mcControl.sv */
`timescale 1ns/1ps

module mcControl (
	input  logic                   CLK,
	input  logic                   RSTn,
	input  rvPkg::opcodeT          opcode,
	output rvPkg::ctrlT            ctrl,
	output logic                   memWrN,
	output logic                   memRd,
	output logic [rvPkg::xlen-1:0] instCount
);
	import rvPkg::*;

	stateT state;
	stateT nextState;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			state <= stIdle;
		end else begin
			state <= nextState;
		end
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			instCount <= '0;
		end else if (nextState == stFetch) begin
			instCount <= instCount + 1'b1; // One per started instruction
		end
	end

	always_comb begin
		case (state)
			stIdle:   nextState = stFetch;
			stFetch:  nextState = stDecode;
			stDecode: begin
				case (opcode)
					opJal:    nextState = stJal;
					opItype:  nextState = stAddrCalc;
					opRtype:  nextState = stRexec;
					opJalr:   nextState = stJalr;
					opBranch: nextState = stBranch;
					opLoad:   nextState = stAddrCalc;
					opStore:  nextState = stAddrCalc;
					default:  nextState = stFetch; // Unsupported, skip it
				endcase
			end
			stAddrCalc: begin
				case (opcode)
					opStore: nextState = stMemWr;
					opLoad:  nextState = stMemRd;
					opItype: nextState = stAluWb;
					default: nextState = stFetch;
				endcase
			end
			stJal:    nextState = stAluWb;
			stJalr:   nextState = stAluWb;
			stRexec:  nextState = stAluWb;
			stBranch: nextState = stBrDone;
			stMemRd:  nextState = stMemWb;
			default:  nextState = stFetch; // All writeback and done states
		endcase
	end

	always_comb begin
		ctrl.pcWr     = 1'b0;
		ctrl.pcWrCond = 1'b0;
		ctrl.irWr     = 1'b0;
		ctrl.rfWe     = 1'b0;
		ctrl.aSel     = aRs1;
		ctrl.bSel     = bImm;
		ctrl.pcSrc    = pcAluOut;
		ctrl.wbSel    = wbAluOut;
		ctrl.state    = state;
		memWrN        = 1'b1;
		memRd         = 1'b0;
		case (state)
			stFetch: begin
				ctrl.irWr = 1'b1;
				ctrl.aSel = aPc;
				ctrl.bSel = bFour; // ALU out gets PC+4
			end
			stDecode: begin
				ctrl.pcWr = 1'b1; // PC+4 from fetch
				ctrl.aSel = aPc;  // Branch and jump target
			end
			stJal: begin
				ctrl.pcWr = 1'b1;
				ctrl.aSel = aPc;
				ctrl.bSel = bFour;
			end
			stJalr: begin
				ctrl.pcWr  = 1'b1;
				ctrl.pcSrc = pcAlu; // rs1 + imm
			end
			stRexec: ctrl.bSel = bRs2;
			stBranch: begin
				ctrl.bSel     = bRs2;
				ctrl.pcWrCond = 1'b1;
			end
			stMemRd: memRd = 1'b1;
			stMemWr: memWrN = 1'b0;
			stMemWb: begin
				ctrl.rfWe  = 1'b1;
				ctrl.wbSel = wbMdr;
			end
			stAluWb: ctrl.rfWe = 1'b1;
			default: ;
		endcase
	end

endmodule

/* source/mcDatapath.sv */
`timescale 1ns/1ps

module mcDatapath #(
	parameter logic [rvPkg::xlen-1:0] resetPc = '0
) (
	input  logic                   CLK,
	input  logic                   RSTn,
	input  rvPkg::ctrlT            ctrl,
	input  logic                   memWrN,
	input  logic                   memRd,
	input  logic [rvPkg::xlen-1:0] iRData,
	input  logic [rvPkg::xlen-1:0] dRData,
	output rvPkg::opcodeT          opcode,
	output rvPkg::iMemReqT         iMemReq,
	output rvPkg::dMemReqT         dMemReq
);
	import rvPkg::*;

	logic [xlen-1:0] pc;
	instrT           ir;
	logic [xlen-1:0] aReg;
	logic [xlen-1:0] bReg;
	logic [xlen-1:0] aluOut;
	logic [xlen-1:0] mdr;
	logic [xlen-1:0] rData1;
	logic [xlen-1:0] rData2;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] aluA;
	logic [xlen-1:0] aluB;
	logic [xlen-1:0] aluResult;
	logic [xlen-1:0] pcNext;
	logic [xlen-1:0] wbData;
	logic            zero;
	logic            brTaken;
	logic            linkSel;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= resetPc;
		end else if (ctrl.pcWr || (ctrl.pcWrCond && brTaken)) begin
			pc <= pcNext;
		end
	end

	always_ff @(posedge CLK) begin
		if (ctrl.irWr) begin
			ir <= instrT'(iRData);
		end
		if (memRd) begin
			mdr <= dRData;
		end
		aReg   <= rData1;
		bReg   <= rData2;
		aluOut <= linkSel ? pc : aluResult; // PC already holds the link in jump states
	end

	assign linkSel = (ctrl.state == stJal) || (ctrl.state == stJalr);

	// Immediate by format
	always_comb begin
		case (ir.rFmt.opcode)
			opStore:  imm = {{(xlen-12){ir.sFmt.imm11_5[6]}}, ir.sFmt.imm11_5, ir.sFmt.imm4_0};
			opBranch: imm = {{(xlen-12){ir.bFmt.imm12}}, ir.bFmt.imm11, ir.bFmt.imm10_5,
				ir.bFmt.imm4_1, 1'b0};
			opJal:    imm = {{(xlen-20){ir.jFmt.imm20}}, ir.jFmt.imm19_12, ir.jFmt.imm11,
				ir.jFmt.imm10_1, 1'b0};
			default:  imm = {{(xlen-12){ir.iFmt.imm12[11]}}, ir.iFmt.imm12};
		endcase
	end

	assign aluA = (ctrl.aSel == aRs1) ? aReg : pc;

	always_comb begin
		case (ctrl.bSel)
			bRs2:    aluB = bReg;
			bImm:    aluB = imm;
			default: aluB = 32'd4;
		endcase
	end

	always_comb begin
		case (ir.bFmt.funct3)
			3'b000:  brTaken = zero;  // BEQ
			3'b001:  brTaken = !zero; // BNE
			default: brTaken = 1'b0;
		endcase
	end

	// JALR clears bit 0 of its target
	assign pcNext = (ctrl.pcSrc == pcAluOut) ? aluOut : {aluResult[xlen-1:1], 1'b0};
	assign wbData = (ctrl.wbSel == wbMdr) ? mdr : aluOut;

	regFile uRegFile (
		.CLK    (CLK),
		.rAddr1 (ir.rFmt.rs1),
		.rAddr2 (ir.rFmt.rs2),
		.wAddr  (ir.rFmt.rd),
		.wEn    (ctrl.rfWe),
		.wData  (wbData),
		.rData1 (rData1),
		.rData2 (rData2)
	);

	aluUnit uAlu (
		.a      (aluA),
		.b      (aluB),
		.instr  (ir),
		.state  (ctrl.state),
		.result (aluResult),
		.zero   (zero)
	);

	assign opcode = ir.rFmt.opcode;

	assign iMemReq.csN  = !ctrl.irWr;
	assign iMemReq.addr = pc;

	assign dMemReq.csN   = !(memRd || !memWrN); // Selected only on access
	assign dMemReq.wEn   = memWrN;
	assign dMemReq.be    = 4'b1111;
	assign dMemReq.addr  = aluOut;
	assign dMemReq.wData = bReg;

endmodule

/* source/mcCpuCore.sv */
`timescale 1ns/1ps

module mcCpuCore #(
	parameter logic [rvPkg::xlen-1:0] resetPc = '0
) (
	input  logic                   CLK,
	input  logic                   RSTn,
	input  logic [rvPkg::xlen-1:0] iRData,
	input  logic [rvPkg::xlen-1:0] dRData,
	output rvPkg::iMemReqT         iMemReq,
	output rvPkg::dMemReqT         dMemReq,
	output logic [rvPkg::xlen-1:0] instCount
);
	import rvPkg::*;

	ctrlT   ctrl;
	opcodeT opcode;
	logic   memWrN;
	logic   memRd;

	mcControl uControl (
		.CLK       (CLK),
		.RSTn      (RSTn),
		.opcode    (opcode),
		.ctrl      (ctrl),
		.memWrN    (memWrN),
		.memRd     (memRd),
		.instCount (instCount)
	);

	mcDatapath #(
		.resetPc (resetPc)
	) uDatapath (
		.CLK     (CLK),
		.RSTn    (RSTn),
		.ctrl    (ctrl),
		.memWrN  (memWrN),
		.memRd   (memRd),
		.iRData  (iRData),
		.dRData  (dRData),
		.opcode  (opcode),
		.iMemReq (iMemReq),
		.dMemReq (dMemReq)
	);

endmodule

/* test/cpuCheck_properties.sv */
`timescale 1ns/1ps

module cpuCheck_properties (
	input logic         CLK,
	input logic         RSTn,
	input rvPkg::stateT state,
	input logic         rfWe,
	input logic         memWrN
);
	import rvPkg::*;

	int         failCount = 0; // Read by the testbench summary
	logic [3:0] gap;          // Cycles since the last fetch
	logic       seen;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			gap  <= '0;
			seen <= 1'b0;
		end else if (state == stFetch) begin
			gap  <= 4'd1;
			seen <= 1'b1;
		end else begin
			gap <= gap + 4'd1;
		end
	end

	assert property (@(posedge CLK) disable iff (RSTn) state == stFetch |=> state == stDecode)
		else begin failCount++; $error("fetch not followed by decode"); end

	assert property (@(posedge CLK) disable iff (RSTn)
		(state == stFetch && seen) |-> (gap == 4'd2 || gap == 4'd4 || gap == 4'd5))
		else begin failCount++; $error("fetch spacing of %0d cycles", gap); end

	assert property (@(posedge CLK) disable iff (RSTn) !memWrN |-> state == stMemWr)
		else begin failCount++; $error("write enable outside the store state"); end

	assert property (@(posedge CLK) disable iff (RSTn)
		rfWe |-> (state == stAluWb || state == stMemWb))
		else begin failCount++; $error("register write outside writeback"); end

endmodule

bind mcControl cpuCheck_properties uCheck (
	.CLK    (CLK),
	.RSTn   (RSTn),
	.state  (state),
	.rfWe   (ctrl.rfWe),
	.memWrN (memWrN)
);

/* test/tbCpu.sv */
`timescale 1ns/1ps

module tbCpu;
	import rvPkg::*;

	localparam logic [31:0] resetPc = 32'h40;
	localparam logic [31:0] c1 = 32'd1443;
	localparam logic [31:0] c2 = 32'hFFFFFFFD; // -3
	localparam int pathCount = 40;  // Instructions started up to the last store
	localparam int loopPasses = 5;
	localparam int progLen = 45;
	localparam int timeoutCycles = progLen * 5 * 2 + 150;

	logic CLK = 1'b0;
	logic RSTn;
	logic [31:0] iRData;
	logic [31:0] dRData;
	iMemReqT iMemReq;
	dMemReqT dMemReq;
	logic [31:0] instCount;

	logic [31:0] imem [0:63];
	logic [31:0] dmem [0:63];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	string expName [$];
	int n = 0;
	int seed = 17;
	int cycles = 0;
	int valErrors = 0;
	int otherErrors = 0;

	logic [2:0] aluF3 [8] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100, 3'b010, 3'b001, 3'b101};
	string aluName [8] = '{"add", "sub", "and", "or", "xor", "slt", "sll", "srl"};

	mcCpuCore #(.resetPc(resetPc)) i_dut (
		.CLK(CLK), .RSTn(RSTn), .iRData(iRData), .dRData(dRData),
		.iMemReq(iMemReq), .dMemReq(dMemReq), .instCount(instCount)
	);

	always #2 CLK = ~CLK;

	assign iRData = imem[iMemReq.addr[7:2]]; // Asynchronous reads
	assign dRData = dmem[dMemReq.addr[7:2]];

	always @(posedge CLK) begin
		if (!dMemReq.csN && !dMemReq.wEn) dmem[dMemReq.addr[7:2]] <= dMemReq.wData;
	end

	function automatic logic [31:0] encodeAddi(input logic [4:0] rd, rs1, input logic [31:0] imm);
		return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] encodeLw(input logic [4:0] rd, rs1, input logic [31:0] imm);
		return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
	endfunction

	function automatic logic [31:0] encodeSw(input logic [31:0] imm, input logic [4:0] rs2, rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] encodeBranch(input logic [31:0] imm,
		input logic [4:0] rs2, rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] encodeJal(input logic [31:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] encodeJalr(input logic [4:0] rd, rs1, input logic [31:0] imm);
		return {imm[11:0], rs1, 3'b000, rd, 7'b1100111};
	endfunction

	// RV32I results of the R-type list above
	function automatic logic [31:0] aluModel(input int k, input logic [31:0] a, b);
		case (k)
			0: return a + b;
			1: return a - b;
			2: return a & b;
			3: return a | b;
			4: return a ^ b;
			5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			6: return a << b[4:0];
			default: return a >> b[4:0];
		endcase
	endfunction

	task automatic emit(input logic [31:0] word);
		imem[resetPc[7:2] + n] = word;
		n++;
	endtask

	task automatic expectStore(input string name, input logic [31:0] addr, data);
		expName.push_back(name);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	task automatic checkVal(input string name, input logic [31:0] expV, actV);
		assert (actV === expV) else begin
			valErrors++;
			$display("error %s: expected %h, actual %h", name, expV, actV);
		end
	endtask

	// Wrong path stores break the program order checked here
	always @(negedge CLK) begin
		if (!RSTn && !dMemReq.csN && !dMemReq.wEn) begin
			if (expAddr.size() == 0) begin
				otherErrors++;
				$display("unexpected store of %h to address %h", dMemReq.wData, dMemReq.addr);
			end else begin
				checkVal({expName[0], " address"}, expAddr[0], dMemReq.addr);
				checkVal(expName[0], expData[0], dMemReq.wData);
				checkVal({expName[0], " byte enable"}, 32'hF, dMemReq.be);
				void'(expName.pop_front());
				void'(expAddr.pop_front());
				void'(expData.pop_front());
			end
		end
	end

	// Every fetch lands on a word boundary
	always @(negedge CLK) begin
		if (!RSTn && !iMemReq.csN) begin
			assert (iMemReq.addr[1:0] == 2'b00) else begin
				otherErrors++;
				$display("fetch from the misaligned address %h", iMemReq.addr);
			end
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= timeoutCycles) begin
			$display("run did not finish within %0d cycles", timeoutCycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		int k;
		int jalPc;
		int jalrPc;
		int propErrors;
		RSTn = 1'b1;
		for (k = 0; k < 64; k++) begin
			imem[k] = 32'h0;
			dmem[k] = $random(seed);
		end
		emit(encodeAddi(1, 0, c1));
		emit(encodeAddi(2, 0, c2));
		for (k = 0; k < 8; k++) begin
			emit({1'b0, k == 1, 5'b0, 5'd2, 5'd1, aluF3[k], 5'd3, 7'b0110011});
			emit(encodeSw(4 * k, 3, 0));
			expectStore(aluName[k], 4 * k, aluModel(k, c1, c2));
		end
		emit(encodeLw(4, 0, 128));
		emit(encodeAddi(4, 4, 1));
		emit(encodeSw(32, 4, 0));
		expectStore("load plus one", 32, dmem[32] + 1);
		emit(encodeLw(5, 0, 4));
		emit(encodeSw(36, 5, 0));
		expectStore("reload", 36, c1 - c2);
		emit(encodeAddi(7, 0, 32'h11)); // Marker of the right path
		emit(encodeAddi(8, 0, 32'h22)); // Marker of the wrong path
		emit(encodeBranch(8, 1, 1, 3'b000));
		emit(encodeSw(40, 8, 0));
		emit(encodeSw(40, 7, 0));
		expectStore("beq taken", 40, 32'h11);
		emit(encodeBranch(8, 2, 1, 3'b000));
		emit(encodeSw(44, 7, 0));
		expectStore("beq not taken", 44, 32'h11);
		emit(encodeBranch(8, 2, 1, 3'b001));
		emit(encodeSw(48, 8, 0));
		emit(encodeSw(48, 7, 0));
		expectStore("bne taken", 48, 32'h11);
		emit(encodeBranch(8, 1, 1, 3'b001));
		emit(encodeSw(52, 7, 0));
		expectStore("bne not taken", 52, 32'h11);
		jalPc = resetPc + 4 * n;
		emit(encodeJal(8, 9));
		emit(encodeSw(56, 8, 0));
		emit(encodeSw(56, 9, 0));
		expectStore("jal link", 56, jalPc + 4);
		emit(encodeAddi(10, 0, resetPc + 4 * (n + 3)));
		jalrPc = resetPc + 4 * n;
		emit(encodeJalr(11, 10, 1)); // Bit 0 of the target is dropped
		emit(encodeSw(60, 8, 0));
		emit(encodeSw(60, 11, 0));
		expectStore("jalr link", 60, jalrPc + 4);
		emit(encodeAddi(12, 0, pathCount));
		emit(encodeSw(64, 12, 0));
		expectStore("count store", 64, pathCount);
		emit(encodeJal(0, 0));

		repeat (3) begin
			@(negedge CLK);
			checkVal("reset iMem csN", 1, iMemReq.csN);
			checkVal("reset dMem csN", 1, dMemReq.csN);
			checkVal("reset wEn", 1, dMemReq.wEn);
			checkVal("reset instCount", 0, instCount);
		end
		RSTn = 1'b0;
		@(negedge CLK);
		checkVal("first fetch csN", 0, iMemReq.csN);
		checkVal("first fetch address", resetPc, iMemReq.addr);

		while (expAddr.size() > 0) @(posedge CLK);
		repeat (4 * loopPasses) @(posedge CLK);
		@(negedge CLK);
		checkVal("instCount", pathCount + 1 + loopPasses, instCount);

		propErrors = i_dut.uControl.uCheck.failCount;
		$display("errors: %0d value, %0d other, %0d property", valErrors, otherErrors, propErrors);
		if (valErrors + otherErrors + propErrors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* tb.f */
source/rvPkg.sv
source/regFile.sv
source/aluUnit.sv
source/mcControl.sv
source/mcDatapath.sv
source/mcCpuCore.sv
test/cpuCheck_properties.sv
test/tbCpu.sv

/* Makefile */
.PHONY: run clean

obj_dir/VtbCpu: tb.f $(shell grep -v '^+' tb.f)
	verilator --binary --timing --assert -Wno-fatal --top-module tbCpu -f tb.f -Mdir obj_dir

sim.log: obj_dir/VtbCpu
	./obj_dir/VtbCpu +verilator+error+limit+100 > sim.log 2>&1 || true

run: sim.log
	cat sim.log
	grep -qx "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
